// File: hdl/baseband_timing_pkg.sv
`default_nettype none

package baseband_timing_pkg;

  // one master TX slot and one RX slot, each split in two halves
  localparam int HALF_SLOTS_PER_PAIR = 4;

  // phase counter widths seen by the slot timer
  localparam int PAIR_PHASE_W = $clog2(HALF_SLOTS_PER_PAIR);
  localparam int HALF_PHASE_W = 4;

  // strobes produced once per half-slot tick by the slot timer
  typedef struct packed {
    logic                    tx_slot_start;  // first half of a master TX slot
    logic                    rx_slot_end;    // last half of a master RX slot
    logic                    half_tick;      // every half slot
    logic [HALF_PHASE_W-1:0] half_phase;     // half slots since inquiry start, modulo 16
  } slot_strobe_t;

endpackage

`default_nettype wire

// File: hdl/inquiry_pkg.sv
`default_nettype none

package inquiry_pkg;

  // Ninquiry below this value is raised to it
  localparam logic [9:0] NINQUIRY_MIN = 10'd256;

  // RX slot ends in one repetition of a train
  localparam int TRAIN_SLOTS = 8;

  // inquiry channel set
  localparam int N_CHANNELS = 32;
  localparam int CHANNEL_W  = $clog2(N_CHANNELS);

  // train offsets into the channel set
  localparam logic [CHANNEL_W-1:0] KOFFSET_A = CHANNEL_W'(24);
  localparam logic [CHANNEL_W-1:0] KOFFSET_B = CHANNEL_W'(8);

  // software registers, stable while inquiry is high
  typedef struct packed {
    logic [9:0]  ninquiry;
    logic [15:0] inquiry_length;      // in master TX slots
    logic [15:0] ext_inquiry_length;  // added to inquiry_length with 16 bit wrap
  } inquiry_cfg_t;

  typedef struct packed {
    logic       a_train;    // 1 while the A train is being sent
    logic [3:0] ab_count;   // completed A/B pairs
    logic       timeout_p;  // high from one tx slot start to the next
  } inquiry_stat_t;

  typedef struct packed {
    logic                 valid;
    logic                 a_train;
    logic [CHANNEL_W-1:0] channel;
  } hop_t;

endpackage

`default_nettype wire

// File: hdl/slot_timer.sv
`timescale 1ns/10ps
`default_nettype none

module slot_timer
  import baseband_timing_pkg::*;
(
  input  logic         clk_6M,
  input  logic         rstz,
  input  logic         half_slot_tick,
  input  logic         inquiry,
  output slot_strobe_t strobe
);

  logic [HALF_PHASE_W-1:0] half_cnt;
  logic [PAIR_PHASE_W-1:0] slot_phase;
  logic                    tick;
  slot_strobe_t            strobe_q;

  // ticks only count while inquiry runs, so the master realigns on every start
  assign tick = half_slot_tick & inquiry;

  // the slot pair phase is the low part of the half slot count
  assign slot_phase = half_cnt[PAIR_PHASE_W-1:0];

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      half_cnt <= '0;
    end
    else if (!inquiry)
    begin
      half_cnt <= '0;
    end
    else if (tick)
    begin
      half_cnt <= half_cnt + 1'b1;  // wraps at 16
    end
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      strobe_q <= '0;
    end
    else
    begin
      strobe_q.tx_slot_start <= tick & (slot_phase == '0);
      strobe_q.rx_slot_end   <= tick & (slot_phase == PAIR_PHASE_W'(HALF_SLOTS_PER_PAIR - 1));
      strobe_q.half_tick     <= tick;
      if (!inquiry)
      begin
        strobe_q.half_phase <= '0;
      end
      else if (tick)
      begin
        strobe_q.half_phase <= half_cnt;  // phase of the half slot just started
      end
    end
  end

  assign strobe = strobe_q;

endmodule

`default_nettype wire

// File: hdl/inquiry_train_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module inquiry_train_ctrl
  import baseband_timing_pkg::*;
  import inquiry_pkg::*;
(
  input  logic          clk_6M,
  input  logic          rstz,
  input  logic          inquiry,
  input  slot_strobe_t  strobe,
  input  inquiry_cfg_t  cfg,
  output inquiry_stat_t stat
);

  localparam int              P_W    = $clog2(TRAIN_SLOTS);
  localparam logic [P_W-1:0]  P_LAST = P_W'(TRAIN_SLOTS - 1);

  logic [9:0]     ninq_eff;
  logic [P_W-1:0] p_count;
  logic [9:0]     train_count;
  logic           rep_done;
  logic           train_done;
  logic           b_phase;
  logic [3:0]     ab_count;
  logic [15:0]    to_count;
  logic [15:0]    inq_len;
  logic           timeout_p;

  assign ninq_eff = (cfg.ninquiry >= NINQUIRY_MIN) ? cfg.ninquiry : NINQUIRY_MIN;

  // one repetition is 8 RX slot ends, a train phase is Ninquiry+1 repetitions
  assign rep_done   = strobe.rx_slot_end & (p_count == P_LAST);
  assign train_done = rep_done & (train_count == ninq_eff);

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      p_count <= '0;
    else if (!inquiry)
      p_count <= '0;
    else if (strobe.rx_slot_end)
      p_count <= p_count + 1'b1;
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      train_count <= '0;
    else if (!inquiry || train_done)
      train_count <= '0;
    else if (rep_done)
      train_count <= train_count + 1'b1;
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      b_phase  <= 1'b0;
      ab_count <= '0;
    end
    else if (!inquiry)
    begin
      b_phase  <= 1'b0;
      ab_count <= '0;
    end
    else if (train_done)
    begin
      b_phase <= ~b_phase;
      if (b_phase)
        ab_count <= ab_count + 1'b1;  // a B phase just ended
    end
  end

  // timeout budget, the sum wraps at 16 bits like the register adder
  assign inq_len = cfg.inquiry_length + cfg.ext_inquiry_length;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      to_count <= '0;
    else if (!inquiry || timeout_p)
      to_count <= '0;
    else if (strobe.tx_slot_start)
      to_count <= to_count + 1'b1;
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      timeout_p <= 1'b0;
    else if (!inquiry)
      timeout_p <= 1'b0;
    else if (strobe.tx_slot_start)
      timeout_p <= ~timeout_p & (to_count > inq_len);  // lasts one TX slot
  end

  assign stat = '{a_train: ~b_phase, ab_count: ab_count, timeout_p: timeout_p};

endmodule

`default_nettype wire

// File: hdl/inquiry_hop_sel.sv
`timescale 1ns/10ps
`default_nettype none

module inquiry_hop_sel
  import baseband_timing_pkg::*;
  import inquiry_pkg::*;
(
  input  logic         clk_6M,
  input  logic         rstz,
  input  slot_strobe_t strobe,
  input  logic         a_train,
  output hop_t         hop
);

  logic [CHANNEL_W-1:0] koffset;
  logic [CHANNEL_W-1:0] channel_next;
  logic                 valid_q;
  logic                 a_train_q;
  logic [CHANNEL_W-1:0] channel_q;

  assign koffset = a_train ? KOFFSET_A : KOFFSET_B;

  // the sum wraps at the size of the channel set
  assign channel_next = koffset + CHANNEL_W'(strobe.half_phase);

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= strobe.half_tick;  // one pulse per half slot
    end
  end

  always_ff @(posedge clk_6M)
  begin
    if (strobe.half_tick)
    begin
      a_train_q <= a_train;
      channel_q <= channel_next;
    end
  end

  assign hop = '{valid: valid_q, a_train: a_train_q, channel: channel_q};

endmodule

`default_nettype wire

// File: hdl/inquiry_status.sv
`timescale 1ns/10ps
`default_nettype none

module inquiry_status (
  input  logic clk_6M,
  input  logic rstz,
  input  logic timeout_p,
  input  logic status_clr,
  output logic timeout_flag
);

  logic timeout_q;
  logic timeout_rise;

  // timeout_p stays high for a whole TX slot, only its first cycle counts
  assign timeout_rise = timeout_p & ~timeout_q;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      timeout_q <= 1'b0;
    end
    else
    begin
      timeout_q <= timeout_p;
    end
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      timeout_flag <= 1'b0;
    end
    else if (timeout_rise)
    begin
      timeout_flag <= 1'b1;  // a new timeout beats a clear in the same cycle
    end
    else if (status_clr)
    begin
      timeout_flag <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/inquiry_top.sv
`timescale 1ns/10ps
`default_nettype none

module inquiry_top
  import baseband_timing_pkg::*;
  import inquiry_pkg::*;
(
  input  logic          clk_6M,
  input  logic          rstz,
  input  logic          half_slot_tick,
  input  logic          inquiry,
  input  inquiry_cfg_t  cfg,
  input  logic          status_clr,
  output inquiry_stat_t stat,
  output hop_t          hop,
  output logic          timeout_flag
);

  slot_strobe_t strobe;

  slot_timer u_slot_timer (
    .clk_6M         (clk_6M),
    .rstz           (rstz),
    .half_slot_tick (half_slot_tick),
    .inquiry        (inquiry),
    .strobe         (strobe)
  );

  inquiry_train_ctrl u_train_ctrl (
    .clk_6M  (clk_6M),
    .rstz    (rstz),
    .inquiry (inquiry),
    .strobe  (strobe),
    .cfg     (cfg),
    .stat    (stat)
  );

  inquiry_hop_sel u_hop_sel (
    .clk_6M  (clk_6M),
    .rstz    (rstz),
    .strobe  (strobe),
    .a_train (stat.a_train),
    .hop     (hop)
  );

  inquiry_status u_status (
    .clk_6M       (clk_6M),
    .rstz         (rstz),
    .timeout_p    (stat.timeout_p),
    .status_clr   (status_clr),
    .timeout_flag (timeout_flag)
  );

endmodule

`default_nettype wire

// File: dv/inquiry_chk.sv
`timescale 1ns/10ps
`default_nettype none

module inquiry_chk
  import inquiry_pkg::*;
(
  input wire logic          clk_6M,
  input wire logic          rstz,
  input wire logic          half_slot_tick,
  input wire logic          inquiry,
  input wire inquiry_cfg_t  cfg,
  input wire logic          status_clr,
  input wire inquiry_stat_t stat,
  input wire hop_t          hop,
  input wire logic          timeout_flag
);

  int unsigned fail_count = 0;

  logic        tick_in;
  logic        tx_tick;
  logic        toggle_tick;
  logic [3:0]  tick_cnt;
  logic [3:0]  exp_phase;
  logic [9:0]  ninq_eff;
  logic [15:0] inq_len;
  int          period;
  int          phase_ticks;
  int          to_cnt;
  logic        exp_to;
  logic        exp_b;
  logic [3:0]  exp_ab;

  assign tick_in     = half_slot_tick & inquiry;
  assign tx_tick     = tick_in & (tick_cnt[1:0] == 2'd0);  // first half of the TX slot
  assign ninq_eff    = (cfg.ninquiry < 10'd256) ? 10'd256 : cfg.ninquiry;
  assign period      = (int'(ninq_eff) + 1) * 32;  // ticks per train phase
  assign toggle_tick = tick_in & (phase_ticks == period - 1);
  assign inq_len     = cfg.inquiry_length + cfg.ext_inquiry_length;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      tick_cnt    <= '0;
      exp_phase   <= '0;
      phase_ticks <= 0;
      to_cnt      <= 0;
      exp_to      <= 1'b0;
      exp_b       <= 1'b0;
      exp_ab      <= '0;
    end
    else if (!inquiry)
    begin
      tick_cnt    <= '0;
      phase_ticks <= 0;
      to_cnt      <= 0;
      exp_to      <= 1'b0;
      exp_b       <= 1'b0;
      exp_ab      <= '0;
    end
    else if (tick_in)
    begin
      tick_cnt    <= tick_cnt + 4'd1;
      exp_phase   <= tick_cnt;
      phase_ticks <= toggle_tick ? 0 : phase_ticks + 1;
      if (toggle_tick)
      begin
        exp_b <= ~exp_b;
        if (exp_b)
          exp_ab <= exp_ab + 4'd1;  // a B phase ends here
      end
      if (tx_tick)
      begin
        if (exp_to)
        begin
          exp_to <= 1'b0;  // the pulse lasts one TX slot
          to_cnt <= 0;
        end
        else if (to_cnt + 1 == int'(inq_len) + 2)
        begin
          exp_to <= 1'b1;
          to_cnt <= 0;
        end
        else
        begin
          to_cnt <= to_cnt + 1;
        end
      end
    end
  end

  a_idle_stat: assert property (@(posedge clk_6M) disable iff (!rstz)
    !$past(inquiry) |-> stat.a_train && stat.ab_count == 4'd0 && !stat.timeout_p)
    else begin fail_count = fail_count + 1; $error("stat not cleared while idle"); end

  a_hop_valid: assert property (@(posedge clk_6M) disable iff (!rstz)
    hop.valid == $past(tick_in, 2))
    else begin fail_count = fail_count + 1; $error("hop valid out of step with tick"); end

  a_hop_channel: assert property (@(posedge clk_6M) disable iff (!rstz)
    hop.valid |-> hop.a_train == $past(stat.a_train) &&
                  hop.channel == 5'(($past(stat.a_train) ? 24 : 8) + $past(exp_phase)))
    else begin fail_count = fail_count + 1; $error("wrong hop channel"); end

  a_train_toggle: assert property (@(posedge clk_6M) disable iff (!rstz)
    inquiry && $past(inquiry) && $past(inquiry, 2) |->
      (stat.a_train != $past(stat.a_train)) == $past(toggle_tick, 2))
    else begin fail_count = fail_count + 1; $error("a_train toggled at wrong tick"); end

  a_pair_count: assert property (@(posedge clk_6M) disable iff (!rstz)
    inquiry && $past(inquiry) |-> stat.ab_count == $past(exp_ab))
    else begin fail_count = fail_count + 1; $error("wrong A/B pair count"); end

  a_timeout: assert property (@(posedge clk_6M) disable iff (!rstz)
    inquiry && $past(inquiry) |-> stat.timeout_p == $past(exp_to))
    else begin fail_count = fail_count + 1; $error("timeout pulse at wrong slot"); end

  a_flag_set: assert property (@(posedge clk_6M) disable iff (!rstz)
    $past($rose(stat.timeout_p)) |-> timeout_flag)
    else begin fail_count = fail_count + 1; $error("timeout flag did not set"); end

  a_flag_clear: assert property (@(posedge clk_6M) disable iff (!rstz)
    !$past($rose(stat.timeout_p)) |->
      timeout_flag == ($past(timeout_flag) && !$past(status_clr)))
    else begin fail_count = fail_count + 1; $error("timeout flag changed without cause"); end

endmodule

bind inquiry_top inquiry_chk u_chk (
  .clk_6M         (clk_6M),
  .rstz           (rstz),
  .half_slot_tick (half_slot_tick),
  .inquiry        (inquiry),
  .cfg            (cfg),
  .status_clr     (status_clr),
  .stat           (stat),
  .hop            (hop),
  .timeout_flag   (timeout_flag)
);

`default_nettype wire

// File: dv/inquiry_tb.sv
`timescale 1ns/10ps
`default_nettype none

module inquiry_tb
  import inquiry_pkg::*;
();

  localparam int          MAX_CYCLES = 200000;  // two A/B pairs plus the timeout tests
  localparam logic [31:0] SEED       = 32'he19b04f1;

  logic          clk_6M;
  logic          rstz;
  logic          half_slot_tick;
  logic          inquiry;
  inquiry_cfg_t  cfg;
  logic          status_clr;
  inquiry_stat_t stat;
  hop_t          hop;
  logic          timeout_flag;

  int          cycle_count = 0;
  int          tb_errors = 0;
  int          tests_run = 0;
  int          errors_before;
  logic [31:0] lcg_state = SEED;
  logic [31:0] clr_state = SEED;
  logic        rand_clr_en = 1'b0;
  logic        clr_on_rise_en = 1'b0;
  logic        clr_req = 1'b0;
  logic        prev_to = 1'b0;

  inquiry_top dut (
    .clk_6M         (clk_6M),
    .rstz           (rstz),
    .half_slot_tick (half_slot_tick),
    .inquiry        (inquiry),
    .cfg            (cfg),
    .status_clr     (status_clr),
    .stat           (stat),
    .hop            (hop),
    .timeout_flag   (timeout_flag)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int total_errors();
    return tb_errors + int'(dut.u_chk.fail_count);
  endfunction

  initial
  begin
    clk_6M = 1'b0;
    forever #20 clk_6M = ~clk_6M;
  end

  // tick every second cycle, status_clr from random or on request
  initial
  begin
    forever
    begin
      @(posedge clk_6M);
      #2;
      half_slot_tick = ~half_slot_tick;
      status_clr = clr_req;
      clr_req = 1'b0;
      if (rand_clr_en)
      begin
        clr_state = lcg_next(clr_state);
        status_clr = status_clr | (clr_state[31:26] == 6'd0);
      end
      if (clr_on_rise_en && stat.timeout_p && !prev_to)
        status_clr = 1'b1;  // lands on the cycle the flag sets
      prev_to = stat.timeout_p;
    end
  end

  initial
  begin
    forever
    begin
      @(posedge clk_6M);
      cycle_count = cycle_count + 1;
      if (cycle_count >= MAX_CYCLES)
      begin
        $display("run stopped, limit of %0d cycles reached", MAX_CYCLES);
        $display("Done: errors found");
        $finish;
      end
    end
  end

  task automatic step(input int n);
    repeat (n) @(posedge clk_6M);
    #2;
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      tb_errors = tb_errors + 1;
    end
  endtask

  task automatic start_inquiry(input logic [9:0] ninq, input logic [15:0] len,
                               input logic [15:0] ext);
    cfg = '{ninquiry: ninq, inquiry_length: len, ext_inquiry_length: ext};
    inquiry = 1'b1;
  endtask

  task automatic stop_inquiry();
    inquiry = 1'b0;
    step(4);
    check_value("stat.ab_count", 32'(stat.ab_count), 32'h0);
  endtask

  task automatic wait_train_toggle();
    logic start;
    start = stat.a_train;
    while (stat.a_train == start)
      step(1);
  endtask

  task automatic wait_timeout_rise(input int n);
    repeat (n)
    begin
      while (stat.timeout_p)
        step(1);
      while (!stat.timeout_p)
        step(1);
    end
  endtask

  task automatic begin_test();
    errors_before = total_errors();
    tests_run = tests_run + 1;
  endtask

  task automatic report_test(input string name);
    int n;
    n = total_errors() - errors_before;
    $display("test %-18s %s (%0d errors)", name, (n == 0) ? "ok" : "FAILED", n);
  endtask

  initial
  begin
    rstz = 1'b0;
    half_slot_tick = 1'b0;
    inquiry = 1'b0;
    cfg = '0;
    status_clr = 1'b0;
    repeat (4) @(posedge clk_6M);
    #2;
    rstz = 1'b1;

    begin_test();
    step(40);
    check_value("timeout_flag", 32'(timeout_flag), 32'h0);
    check_value("stat.a_train", 32'(stat.a_train), 32'h1);
    report_test("reset_idle");

    begin_test();
    lcg_state = lcg_next(lcg_state);
    start_inquiry(lcg_state[9:0], 16'h7fff, 16'h7fff);
    step(300);
    stop_inquiry();
    report_test("channel_index");

    begin_test();
    lcg_state = lcg_next(lcg_state);
    rand_clr_en = 1'b1;
    start_inquiry({2'b00, lcg_state[7:0]}, 16'(lcg_state[10:8]), 16'(lcg_state[13:11]));
    wait_train_toggle();
    wait_train_toggle();
    step(2);
    check_value("stat.ab_count", 32'(stat.ab_count), 32'h1);
    stop_inquiry();
    report_test("train_below_min");

    begin_test();
    lcg_state = lcg_next(lcg_state);
    start_inquiry(10'd256 + 10'(lcg_state[5:0]), 16'(lcg_state[8:6]), 16'(lcg_state[11:9]));
    wait_train_toggle();
    wait_train_toggle();
    step(2);
    check_value("stat.ab_count", 32'(stat.ab_count), 32'h1);
    stop_inquiry();
    rand_clr_en = 1'b0;
    report_test("train_above_min");

    begin_test();
    start_inquiry(10'd0, 16'hffff, 16'h0003);  // the sum wraps to 2
    wait_timeout_rise(2);
    step(2);
    check_value("timeout_flag", 32'(timeout_flag), 32'h1);
    stop_inquiry();
    report_test("timeout_wrap");

    begin_test();
    clr_on_rise_en = 1'b1;
    start_inquiry(10'd0, 16'd1, 16'd2);
    wait_timeout_rise(2);
    step(2);
    check_value("timeout_flag", 32'(timeout_flag), 32'h1);
    clr_on_rise_en = 1'b0;
    clr_req = 1'b1;
    step(3);
    check_value("timeout_flag", 32'(timeout_flag), 32'h0);
    stop_inquiry();
    report_test("sticky_flag");

    $display("tests run %0d, errors %0d", tests_run, total_errors());
    if (total_errors() == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
hdl/baseband_timing_pkg.sv
hdl/inquiry_pkg.sv
hdl/slot_timer.sv
hdl/inquiry_train_ctrl.sv
hdl/inquiry_hop_sel.sv
hdl/inquiry_status.sv
hdl/inquiry_top.sv
dv/inquiry_chk.sv
dv/inquiry_tb.sv

// File: run.sh
#!/bin/sh
# builds and runs the inquiry testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module inquiry_tb -f filelist.f -o vsim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/vsim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
